//--- hdl/soc_bus_pkg.sv
package soc_bus_pkg;

    // ----------------------------
    // Bus widths
    // ----------------------------
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BE_W       = 4;

    // Word address of each RAM, 4 KiB each
    localparam int RAM_ADDR_W = 10;

    // ----------------------------
    // Address map, bits 31 to 24
    // ----------------------------
    localparam logic [7:0] IRAM_BASE_TOP   = 8'h00;
    localparam logic [7:0] DRAM_BASE_TOP   = 8'h02;
    localparam logic [7:0] UART_BASE_TOP   = 8'hA0;
    localparam logic [7:0] I2C_BASE_TOP    = 8'hE0;
    localparam logic [7:0] PINMUX_BASE_TOP = 8'hF0;

    // UART register offsets in the low 16 address bits
    localparam logic [15:0] UART_DATA_OFS = 16'h0000;
    localparam logic [15:0] UART_BUSY_OFS = 16'h0004;

    // Cycles per UART bit, small for simulation
    localparam int UART_DIV   = 8;
    localparam int UART_DIV_W = $clog2(UART_DIV);

    // Decoded target of a shared bus access
    typedef enum logic [2:0] {
        TGT_IRAM,
        TGT_DRAM,
        TGT_UART,
        TGT_EXT,
        TGT_NONE
    } bus_target_e;

endpackage

//--- hdl/obi_bus_if.sv
interface obi_bus_if import soc_bus_pkg::*; ();

    // Request channel
    logic              req;
    logic              gnt;
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;

    // Response channel
    logic              rvalid;
    logic [DATA_W-1:0] rdata;

    modport master (
        output req, addr, we, be, wdata,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, addr, we, be, wdata,
        output gnt, rvalid, rdata
    );

endinterface

//--- hdl/obi_ram_arbiter.sv
module obi_ram_arbiter import soc_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,

    // Instruction port, read only
    input  logic              instr_req_i,
    input  logic [ADDR_W-1:0] instr_addr_i,
    output logic              instr_gnt_o,
    output logic              instr_rvalid_o,
    output logic [DATA_W-1:0] instr_rdata_o,

    // Data port
    input  logic              data_req_i,
    input  logic [ADDR_W-1:0] data_addr_i,
    input  logic              data_we_i,
    input  logic [BE_W-1:0]   data_be_i,
    input  logic [DATA_W-1:0] data_wdata_i,
    output logic              data_gnt_o,
    output logic              data_rvalid_o,
    output logic [DATA_W-1:0] data_rdata_o,

    obi_bus_if.master         bus_o
);

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_INSTR,
        OWN_DATA
    } owner_e;

    owner_e owner_q;
    owner_e sel;
    logic   granted_q;
    logic   sel_req;

    // Owner is held from the first request cycle, so addr is stable up to gnt
    always_comb begin
        if (owner_q != OWN_NONE) begin
            sel = owner_q;
        end else if (data_req_i) begin
            sel = OWN_DATA;
        end else if (instr_req_i) begin
            sel = OWN_INSTR;
        end else begin
            sel = OWN_NONE;
        end
    end

    // ----------------------------
    // Request mux
    // ----------------------------
    always_comb begin
        case (sel)
            OWN_DATA: begin
                sel_req     = data_req_i;
                bus_o.addr  = data_addr_i;
                bus_o.we    = data_we_i;
                bus_o.be    = data_be_i;
                bus_o.wdata = data_wdata_i;
            end
            OWN_INSTR: begin
                // Fetches are plain word reads
                sel_req     = instr_req_i;
                bus_o.addr  = instr_addr_i;
                bus_o.we    = 1'b0;
                bus_o.be    = '1;
                bus_o.wdata = '0;
            end
            default: begin
                sel_req     = 1'b0;
                bus_o.addr  = '0;
                bus_o.we    = 1'b0;
                bus_o.be    = '0;
                bus_o.wdata = '0;
            end
        endcase
    end

    // No new request goes out between gnt and the matching rvalid
    assign bus_o.req = sel_req && !granted_q;

    assign instr_gnt_o    = bus_o.gnt && (sel == OWN_INSTR);
    assign data_gnt_o     = bus_o.gnt && (sel == OWN_DATA);
    assign instr_rvalid_o = bus_o.rvalid && (owner_q == OWN_INSTR);
    assign data_rvalid_o  = bus_o.rvalid && (owner_q == OWN_DATA);
    assign instr_rdata_o  = bus_o.rdata;
    assign data_rdata_o   = bus_o.rdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            owner_q   <= OWN_NONE;
            granted_q <= 1'b0;
        end else begin
            if (owner_q == OWN_NONE) begin
                owner_q <= sel;
            end else if (bus_o.rvalid) begin
                owner_q <= OWN_NONE;
            end

            if (bus_o.rvalid) begin
                granted_q <= 1'b0;
            end else if (bus_o.gnt) begin
                granted_q <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/soc_bus_decoder.sv
module soc_bus_decoder import soc_bus_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    obi_bus_if.slave              bus_i,
    obi_bus_if.master             ext_o,

    // Shared RAM port signals
    output logic [RAM_ADDR_W-1:0] ram_addr_o,
    output logic                  iram_we_o,
    output logic                  dram_we_o,
    output logic [BE_W-1:0]       ram_be_o,
    output logic [DATA_W-1:0]     ram_wdata_o,
    input  logic [DATA_W-1:0]     iram_rdata_i,
    input  logic [DATA_W-1:0]     dram_rdata_i,

    // UART register block
    output logic                  uart_we_o,
    output logic [7:0]            uart_wdata_o,
    output logic                  uart_sel_busy_o,
    input  logic [DATA_W-1:0]     uart_rdata_i
);

    bus_target_e tgt_now;
    bus_target_e tgt_q;
    logic        gnt_int_q;
    logic        rvalid_int_q;
    logic        req_int;

    // ----------------------------
    // Address decode
    // ----------------------------
    always_comb begin
        case (bus_i.addr[31:24])
            IRAM_BASE_TOP:   tgt_now = TGT_IRAM;
            DRAM_BASE_TOP:   tgt_now = TGT_DRAM;
            UART_BASE_TOP:   tgt_now = TGT_UART;
            I2C_BASE_TOP:    tgt_now = TGT_EXT;
            PINMUX_BASE_TOP: tgt_now = TGT_EXT;
            default:         tgt_now = TGT_NONE;
        endcase
    end

    // Unmapped addresses are served internally with zero data
    assign req_int = bus_i.req && (tgt_now != TGT_EXT);

    // ----------------------------
    // Grant and read-valid
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            gnt_int_q    <= 1'b0;
            rvalid_int_q <= 1'b0;
            tgt_q        <= TGT_NONE;
        end else begin
            gnt_int_q    <= req_int && !gnt_int_q && !rvalid_int_q;
            rvalid_int_q <= gnt_int_q;
            // Remember where the granted access went for the rdata mux
            if (bus_i.gnt) begin
                tgt_q <= tgt_now;
            end
        end
    end

    assign bus_i.gnt    = gnt_int_q || ext_o.gnt;
    assign bus_i.rvalid = rvalid_int_q || ext_o.rvalid;

    // External windows go to the Wishbone bridge
    assign ext_o.req   = bus_i.req && (tgt_now == TGT_EXT);
    assign ext_o.addr  = bus_i.addr;
    assign ext_o.we    = bus_i.we;
    assign ext_o.be    = bus_i.be;
    assign ext_o.wdata = bus_i.wdata;

    // RAM word address, byte offset dropped
    assign ram_addr_o  = bus_i.addr[RAM_ADDR_W+1:2];
    assign ram_be_o    = bus_i.be;
    assign ram_wdata_o = bus_i.wdata;
    assign iram_we_o   = gnt_int_q && bus_i.we && (tgt_now == TGT_IRAM);
    assign dram_we_o   = gnt_int_q && bus_i.we && (tgt_now == TGT_DRAM);

    assign uart_we_o       = gnt_int_q && bus_i.we && (tgt_now == TGT_UART) &&
                             (bus_i.addr[15:0] == UART_DATA_OFS);
    assign uart_wdata_o    = bus_i.wdata[7:0];
    assign uart_sel_busy_o = (bus_i.addr[15:0] == UART_BUSY_OFS);

    // ----------------------------
    // Read data mux
    // ----------------------------
    always_comb begin
        case (tgt_q)
            TGT_IRAM: bus_i.rdata = iram_rdata_i;
            TGT_DRAM: bus_i.rdata = dram_rdata_i;
            TGT_UART: bus_i.rdata = uart_rdata_i;
            TGT_EXT:  bus_i.rdata = ext_o.rdata;
            default:  bus_i.rdata = '0;
        endcase
    end

endmodule

//--- hdl/sram_byte_en.sv
module sram_byte_en import soc_bus_pkg::*; #(
    parameter int DEPTH_W = RAM_ADDR_W
) (
    input  logic               clk_i,
    input  logic [DEPTH_W-1:0] addr_i,
    input  logic               we_i,
    input  logic [BE_W-1:0]    be_i,
    input  logic [DATA_W-1:0]  wdata_i,
    output logic [DATA_W-1:0]  rdata_o
);

    logic [DATA_W-1:0] mem [2**DEPTH_W];

    // Byte lane writes
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < BE_W; i++) begin
            if (we_i && be_i[i]) begin
                mem[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
            end
        end
    end

    // One cycle read latency, old data on a write
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[addr_i];
    end

endmodule

//--- hdl/uart_tx_regs.sv
module uart_tx_regs import soc_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              we_i,
    input  logic              sel_busy_i,
    input  logic [7:0]        wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              ser_tx_o
);

    // Frame is stop, 8 data bits, start; LSB goes out first
    logic [9:0]            shift_q;
    logic [3:0]            bits_left_q;
    logic [UART_DIV_W-1:0] div_q;
    logic                  busy_q;
    logic [7:0]            data_q;

    // ----------------------------
    // Transmitter
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            shift_q     <= '1;
            bits_left_q <= '0;
            div_q       <= '0;
            busy_q      <= 1'b0;
        end else if (!busy_q) begin
            // Writes while busy are dropped
            if (we_i) begin
                shift_q     <= {1'b1, wdata_i, 1'b0};
                bits_left_q <= 4'd10;
                div_q       <= '0;
                busy_q      <= 1'b1;
            end
        end else if (div_q == UART_DIV_W'(UART_DIV - 1)) begin
            div_q       <= '0;
            shift_q     <= {1'b1, shift_q[9:1]};
            bits_left_q <= bits_left_q - 4'd1;
            if (bits_left_q == 4'd1) begin
                busy_q <= 1'b0;
            end
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign ser_tx_o = shift_q[0];

    always_ff @(posedge clk_i) begin
        if (we_i && !busy_q) begin
            data_q <= wdata_i;
        end
        // Sampled in the grant cycle, read out with rvalid
        rdata_o <= sel_busy_i ? {{(DATA_W-1){1'b0}}, busy_q} : {{(DATA_W-8){1'b0}}, data_q};
    end

endmodule

//--- hdl/obi_wb_bridge.sv
module obi_wb_bridge import soc_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,

    obi_bus_if.slave          obi_i,

    // Wishbone classic master
    output logic [ADDR_W-1:0] wb_addr_o,
    output logic [DATA_W-1:0] wb_wdata_o,
    output logic              wb_we_o,
    output logic [BE_W-1:0]   wb_sel_o,
    output logic              wb_stb_o,
    output logic              wb_cyc_o,
    input  logic              wb_ack_i,
    input  logic [DATA_W-1:0] wb_rdata_i
);

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_CYCLE,
        BR_RESPOND
    } br_state_e;

    br_state_e         state_q;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= BR_IDLE;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= (state_q == BR_RESPOND);
            case (state_q)
                BR_IDLE:    if (obi_i.req) state_q <= BR_CYCLE;
                BR_CYCLE:   if (wb_ack_i) state_q <= BR_RESPOND;
                default:    state_q <= BR_IDLE;
            endcase
        end
    end

    // ----------------------------
    // Request and response capture
    // ----------------------------
    always_ff @(posedge clk_i) begin
        if (state_q == BR_IDLE && obi_i.req) begin
            wb_addr_o  <= obi_i.addr;
            wb_wdata_o <= obi_i.wdata;
            wb_we_o    <= obi_i.we;
            wb_sel_o   <= obi_i.be;
        end
        if (state_q == BR_CYCLE && wb_ack_i) begin
            rdata_q <= wb_rdata_i;
        end
    end

    assign wb_cyc_o     = (state_q == BR_CYCLE);
    assign wb_stb_o     = (state_q == BR_CYCLE);
    // gnt comes the cycle after ack, rvalid one cycle later
    assign obi_i.gnt    = (state_q == BR_RESPOND);
    assign obi_i.rvalid = rvalid_q;
    assign obi_i.rdata  = rdata_q;

endmodule

//--- hdl/soc_fabric.sv
module soc_fabric import soc_bus_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,

    // Instruction master
    input  logic              instr_req_i,
    input  logic [ADDR_W-1:0] instr_addr_i,
    output logic              instr_gnt_o,
    output logic              instr_rvalid_o,
    output logic [DATA_W-1:0] instr_rdata_o,

    // Data master
    input  logic              data_req_i,
    input  logic [ADDR_W-1:0] data_addr_i,
    input  logic              data_we_i,
    input  logic [BE_W-1:0]   data_be_i,
    input  logic [DATA_W-1:0] data_wdata_i,
    output logic              data_gnt_o,
    output logic              data_rvalid_o,
    output logic [DATA_W-1:0] data_rdata_o,

    // External Wishbone windows
    output logic [ADDR_W-1:0] wb_addr_o,
    output logic [DATA_W-1:0] wb_wdata_o,
    output logic              wb_we_o,
    output logic [BE_W-1:0]   wb_sel_o,
    output logic              wb_stb_o,
    output logic              wb_cyc_o,
    input  logic              wb_ack_i,
    input  logic [DATA_W-1:0] wb_rdata_i,

    output logic              ser_tx_o
);

    obi_bus_if shared_bus ();
    obi_bus_if ext_bus ();

    logic [RAM_ADDR_W-1:0] ram_addr;
    logic                  iram_we;
    logic                  dram_we;
    logic [BE_W-1:0]       ram_be;
    logic [DATA_W-1:0]     ram_wdata;
    logic [DATA_W-1:0]     iram_rdata;
    logic [DATA_W-1:0]     dram_rdata;
    logic                  uart_we;
    logic [7:0]            uart_wdata;
    logic                  uart_sel_busy;
    logic [DATA_W-1:0]     uart_rdata;

    // ----------------------------
    // Bus
    // ----------------------------
    obi_ram_arbiter arbiter_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .bus_o          (shared_bus.master)
    );

    soc_bus_decoder decoder_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .bus_i           (shared_bus.slave),
        .ext_o           (ext_bus.master),
        .ram_addr_o      (ram_addr),
        .iram_we_o       (iram_we),
        .dram_we_o       (dram_we),
        .ram_be_o        (ram_be),
        .ram_wdata_o     (ram_wdata),
        .iram_rdata_i    (iram_rdata),
        .dram_rdata_i    (dram_rdata),
        .uart_we_o       (uart_we),
        .uart_wdata_o    (uart_wdata),
        .uart_sel_busy_o (uart_sel_busy),
        .uart_rdata_i    (uart_rdata)
    );

    // ----------------------------
    // Targets
    // ----------------------------
    sram_byte_en iram_i (
        .clk_i   (clk_i),
        .addr_i  (ram_addr),
        .we_i    (iram_we),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .rdata_o (iram_rdata)
    );

    sram_byte_en dram_i (
        .clk_i   (clk_i),
        .addr_i  (ram_addr),
        .we_i    (dram_we),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .rdata_o (dram_rdata)
    );

    uart_tx_regs uart_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .we_i       (uart_we),
        .sel_busy_i (uart_sel_busy),
        .wdata_i    (uart_wdata),
        .rdata_o    (uart_rdata),
        .ser_tx_o   (ser_tx_o)
    );

    obi_wb_bridge bridge_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .obi_i      (ext_bus.slave),
        .wb_addr_o  (wb_addr_o),
        .wb_wdata_o (wb_wdata_o),
        .wb_we_o    (wb_we_o),
        .wb_sel_o   (wb_sel_o),
        .wb_stb_o   (wb_stb_o),
        .wb_cyc_o   (wb_cyc_o),
        .wb_ack_i   (wb_ack_i),
        .wb_rdata_i (wb_rdata_i)
    );

endmodule

//--- tests/soc_fabric_props.sv
module soc_fabric_props import soc_bus_pkg::*; (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              req_i,
    input logic              gnt_i,
    input logic              rvalid_i,
    input logic [ADDR_W-1:0] addr_i,
    input logic              cyc_i,
    input logic              stb_i,
    input logic              ack_i
);

    // One rvalid per grant, one cycle later
    a_gnt_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        gnt_i |=> rvalid_i && !gnt_i)
        else $error("rvalid missing after gnt");

    a_rvalid_once: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rvalid_i |-> $past(gnt_i))
        else $error("rvalid without preceding gnt");

    // stb comes with cyc, and both hold until ack
    a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stb_i && !ack_i |=> stb_i && cyc_i)
        else $error("stb or cyc dropped before ack");

    a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_i && !gnt_i |=> $stable(addr_i))
        else $error("addr changed while waiting for gnt");

endmodule

bind soc_bus_decoder soc_fabric_props dec_props_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (bus_i.req),
    .gnt_i    (bus_i.gnt),
    .rvalid_i (bus_i.rvalid),
    .addr_i   (bus_i.addr),
    .cyc_i    (1'b0),
    .stb_i    (1'b0),
    .ack_i    (1'b0)
);

bind obi_wb_bridge soc_fabric_props br_props_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (obi_i.req),
    .gnt_i    (obi_i.gnt),
    .rvalid_i (obi_i.rvalid),
    .addr_i   (obi_i.addr),
    .cyc_i    (wb_cyc_o),
    .stb_i    (wb_stb_o),
    .ack_i    (wb_ack_i)
);

//--- tests/soc_fabric_tb.sv
module soc_fabric_tb import soc_bus_pkg::*; ();

    logic              clk_i;
    logic              rst_ni;
    logic              instr_req_i;
    logic [ADDR_W-1:0] instr_addr_i;
    logic              instr_gnt_o;
    logic              instr_rvalid_o;
    logic [DATA_W-1:0] instr_rdata_o;
    logic              data_req_i;
    logic [ADDR_W-1:0] data_addr_i;
    logic              data_we_i;
    logic [BE_W-1:0]   data_be_i;
    logic [DATA_W-1:0] data_wdata_i;
    logic              data_gnt_o;
    logic              data_rvalid_o;
    logic [DATA_W-1:0] data_rdata_o;
    logic [ADDR_W-1:0] wb_addr_o;
    logic [DATA_W-1:0] wb_wdata_o;
    logic              wb_we_o;
    logic [BE_W-1:0]   wb_sel_o;
    logic              wb_stb_o;
    logic              wb_cyc_o;
    logic              wb_ack_i;
    logic [DATA_W-1:0] wb_rdata_i;
    logic              ser_tx_o;

    // Parsed stimulus
    byte               port_q[$];
    byte               op_q[$];
    logic [ADDR_W-1:0] addr_q[$];
    logic [BE_W-1:0]   be_q[$];
    logic [DATA_W-1:0] wdata_q[$];
    logic [DATA_W-1:0] exp_q[$];

    logic [7:0]        rx_q[$];
    logic [ADDR_W-1:0] wb_wr_addr;
    logic [DATA_W-1:0] wb_wr_data;
    logic [BE_W-1:0]   wb_wr_sel;

    soc_fabric soc_fabric_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
            fail_run("Bus word check failed");
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: UART byte %h, expected %h", $time, got, exp);
            fail_run("UART byte check failed");
        end
    endtask

    task automatic check_wb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                  input logic [BE_W-1:0] sel);
        if (wb_wr_addr !== addr || wb_wr_data !== data || wb_wr_sel !== sel) begin
            $display("Mismatch at %0t: Wishbone write %h/%h/%h, expected %h/%h/%h", $time,
                     wb_wr_addr, wb_wr_data, wb_wr_sel, addr, data, sel);
            fail_run("Wishbone write check failed");
        end
    endtask

    // One OBI transfer on either master port
    task automatic do_access(input logic is_data, input logic we,
                             input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        @(posedge clk_i);
        if (is_data) begin
            data_req_i   <= 1'b1;
            data_addr_i  <= addr;
            data_we_i    <= we;
            data_be_i    <= be;
            data_wdata_i <= wdata;
        end else begin
            instr_req_i  <= 1'b1;
            instr_addr_i <= addr;
        end
        do @(negedge clk_i); while (!(is_data ? data_gnt_o : instr_gnt_o));
        @(posedge clk_i);
        if (is_data) begin
            data_req_i <= 1'b0;
        end else begin
            instr_req_i <= 1'b0;
        end
        do @(negedge clk_i); while (!(is_data ? data_rvalid_o : instr_rvalid_o));
        rdata = is_data ? data_rdata_o : instr_rdata_o;
    endtask

    // Both ports read the same address in the same cycle
    task automatic do_both(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] d_rdata;
        logic [DATA_W-1:0] i_rdata;
        time               d_time;
        time               i_time;
        @(posedge clk_i);
        data_req_i   <= 1'b1;
        data_addr_i  <= addr;
        data_we_i    <= 1'b0;
        data_be_i    <= '1;
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        fork
            begin
                do @(negedge clk_i); while (!data_gnt_o);
                @(posedge clk_i);
                data_req_i <= 1'b0;
                do @(negedge clk_i); while (!data_rvalid_o);
                d_rdata = data_rdata_o;
                d_time  = $time;
            end
            begin
                do @(negedge clk_i); while (!instr_gnt_o);
                @(posedge clk_i);
                instr_req_i <= 1'b0;
                do @(negedge clk_i); while (!instr_rvalid_o);
                i_rdata = instr_rdata_o;
                i_time  = $time;
            end
        join
        check_word("data port", d_rdata, exp);
        check_word("instruction port", i_rdata, exp);
        if (d_time >= i_time) begin
            fail_run("Instruction port was served before the data port");
        end
    endtask

    // ------------------------------
    // Wishbone slave model
    // ------------------------------
    initial begin
        int unsigned delay;
        void'($urandom(32'he0f7_deae));
        forever begin
            @(negedge clk_i);
            if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
                delay = 1 + ($urandom % 4);
                if (wb_we_o) begin
                    wb_wr_addr = wb_addr_o;
                    wb_wr_data = wb_wdata_o;
                    wb_wr_sel  = wb_sel_o;
                end
                repeat (delay) @(posedge clk_i);
                wb_ack_i   <= 1'b1;
                wb_rdata_i <= wb_addr_o ^ 32'h5a5a_5a5a;
                @(posedge clk_i);
                wb_ack_i   <= 1'b0;
            end
        end
    end

    // UART monitor, mid-bit sampling
    initial begin
        logic [7:0] bits;
        forever begin
            @(negedge clk_i);
            if (rst_ni && ser_tx_o === 1'b0) begin
                repeat (UART_DIV / 2) @(negedge clk_i);
                if (ser_tx_o !== 1'b0) begin
                    fail_run("UART start bit was too short");
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (UART_DIV) @(negedge clk_i);
                    bits[i] = ser_tx_o;
                end
                repeat (UART_DIV) @(negedge clk_i);
                if (ser_tx_o !== 1'b1) begin
                    fail_run("UART stop bit missing");
                end
                repeat (UART_DIV / 2) @(negedge clk_i);
                rx_q.push_back(bits);
            end
        end
    end

    initial begin
        int                fd;
        int                n;
        string             line;
        string             port_s;
        string             op_s;
        logic [ADDR_W-1:0] a;
        logic [BE_W-1:0]   b;
        logic [DATA_W-1:0] w;
        logic [DATA_W-1:0] e;
        logic [DATA_W-1:0] rd;
        logic [7:0]        top;

        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_wdata_i = '0;
        wb_ack_i     = 1'b0;
        wb_rdata_i   = '0;

        fd = $fopen("tests/soc_fabric_input.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %s %h %h %h %h", port_s, op_s, a, b, w, e);
            if (n != 6) begin
                fail_run("Malformed line in the stimulus file");
            end
            port_q.push_back(port_s[0]);
            op_q.push_back(op_s[0]);
            addr_q.push_back(a);
            be_q.push_back(b);
            wdata_q.push_back(w);
            exp_q.push_back(e);
        end
        $fclose(fd);

        // Watchdog scaled to the number of transactions
        fork
            begin
                repeat (200 * port_q.size() + 2000) @(posedge clk_i);
                fail_run("Simulation timed out waiting for the DUT");
            end
        join_none

        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (int i = 0; i < port_q.size(); i++) begin
            a   = addr_q[i];
            top = a[31:24];
            if (op_q[i] == "U") begin
                while (rx_q.size() == 0) @(negedge clk_i);
                check_byte(rx_q.pop_front(), exp_q[i][7:0]);
            end else if (port_q[i] == "B") begin
                do_both(a, exp_q[i]);
            end else begin
                do_access(port_q[i] == "D", op_q[i] == "W", a, be_q[i], wdata_q[i], rd);
                if (op_q[i] == "R") begin
                    check_word("read", rd, exp_q[i]);
                end else if (top == I2C_BASE_TOP || top == PINMUX_BASE_TOP) begin
                    check_wb_write(a, wdata_q[i], be_q[i]);
                end
            end
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- tests/soc_fabric_input.txt
# port(I/D/B) op(R/W/U) addr be wdata expected, all hex
# B reads from both ports at once, U waits for a UART byte
D W 02000010 f 11223344 00000000
D R 02000010 f 00000000 11223344
D W 02000010 2 0000aa00 00000000
D W 02000010 8 cc000000 00000000
D R 02000010 f 00000000 cc22aa44
D W 00000040 f 00000013 00000000
I R 00000040 f 00000000 00000013
D W 00000044 f deadbeef 00000000
B R 00000044 f 00000000 deadbeef
D W e0000008 3 0000c0de 00000000
D R e0000008 f 00000000 ba5a5a52
D W f0000100 f 87654321 00000000
D R f0000104 f 00000000 aa5a5b5e
D W a0000000 1 000000a5 00000000
D R a0000004 f 00000000 00000001
D U 00000000 0 00000000 000000a5
D R a0000004 f 00000000 00000000
D R a0000000 f 00000000 000000a5
D W 30000000 f 12345678 00000000
D R 30000000 f 00000000 00000000

//--- tb.f
hdl/soc_bus_pkg.sv
hdl/obi_bus_if.sv
hdl/obi_ram_arbiter.sv
hdl/soc_bus_decoder.sv
hdl/sram_byte_en.sv
hdl/uart_tx_regs.sv
hdl/obi_wb_bridge.sv
hdl/soc_fabric.sv
tests/soc_fabric_props.sv
tests/soc_fabric_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module soc_fabric_tb -o soc_fabric_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/soc_fabric_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
